//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = video_gen_tb
FILELIST  = video_gen.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- hw/text_plane.sv
// ########################################
// text plane, tile and font fetch pipeline
// shifts font rows out as palette indices
// ########################################
`timescale 1ns/10ps

module text_plane (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire video_pkg::vgen_cfg_t   cfg_i,          // display config
    input  wire video_pkg::beam_t       beam_i,         // beam events
    input  wire logic                   video_en_i,     // frame enable from timing
    input  wire logic [15:0]            vram_data_i,    // tile word, cycle after select
    input  wire logic [15:0]            fontram_data_i, // font word, cycle after select
    output logic                        vram_sel_o,
    output logic                        fontram_sel_o,
    output logic [15:0]                 vram_addr_o,
    output logic [11:0]                 fontram_addr_o,
    output logic [3:0]                  pal_index_o     // pixel color index
);

    localparam int unsigned TW = video_pkg::TILE_W;

    logic          fetch_start_q;               // clears phase one cycle late
    logic [2:0]    phase;                       // tile cycle 0..7
    logic [15:0]   tile_addr;                   // next tile word to fetch
    logic [15:0]   row_addr;                    // first word of current tile row
    logic [3:0]    cell_row;                    // row within the font cell
    logic [15:0]   font_addr;
    logic [7:0]    saved_attr;                  // attribute of tile in flight
    logic [7:0]    attr;                        // attribute of tile shifting out
    logic [TW-1:0] shift_q;                     // font row, msb is current pixel

    // 16 high cells use 3 word bits of the row, so one less bank bit
    always_comb begin
        if (cfg_i.font_height[3]) begin
            font_addr = {cfg_i.font_bank[5:1], vram_data_i[7:0], cell_row[3:1]};
        end else begin
            font_addr = {cfg_i.font_bank, vram_data_i[7:0], cell_row[2:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_start_q <= 1'b0;
            phase         <= 3'd0;
            tile_addr     <= 16'h0000;
            row_addr      <= 16'h0000;
            cell_row      <= 4'd0;
            vram_sel_o    <= 1'b0;
            fontram_sel_o <= 1'b0;
            pal_index_o   <= 4'h0;
        end else begin
            fetch_start_q <= beam_i.fetch_start;
            phase         <= fetch_start_q ? 3'd0 : phase + 3'd1;
            vram_sel_o    <= 1'b0;              // selects are single cycle strobes
            fontram_sel_o <= 1'b0;
            pal_index_o   <= shift_q[TW-1] ? attr[3:0] : attr[7:4];   // fore : back

            if (beam_i.fetch_active) begin
                case (phase)
                    3'd0: begin
                        vram_sel_o <= video_en_i;       // tile word read
                        tile_addr  <= tile_addr + 16'd1;
                    end
                    3'd2: begin
                        fontram_sel_o <= video_en_i;    // font row read
                    end
                    default: begin
                    end
                endcase
            end

            if (beam_i.line_end) begin
                if (cell_row == cfg_i.font_height) begin
                    cell_row  <= 4'd0;          // step to next tile row
                    row_addr  <= row_addr + cfg_i.line_width;
                    tile_addr <= row_addr + cfg_i.line_width;
                end else begin
                    cell_row  <= cell_row + 4'd1;
                    tile_addr <= row_addr;      // same tiles again
                end
            end

            if (beam_i.frame_end) begin
                cell_row  <= 4'd0;
                row_addr  <= cfg_i.start_addr;
                tile_addr <= cfg_i.start_addr;
            end
        end
    end

    // memory addresses and pixel data path
    always_ff @(posedge clk) begin
        shift_q <= {shift_q[TW-2:0], 1'b0};
        case (phase)
            3'd0: begin
                vram_addr_o <= tile_addr;
            end
            3'd2: begin
                saved_attr     <= vram_data_i[15:8];
                fontram_addr_o <= font_addr[11:0];
            end
            3'd4: begin
                shift_q <= cell_row[0] ? fontram_data_i[7:0] : fontram_data_i[15:8];
                attr    <= saved_attr;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- hw/vgen_regs.sv
// ########################################
// display config registers
// write decode and registered read mux
// ########################################
`timescale 1ns/10ps

module vgen_regs #(
    parameter int unsigned H_VISIBLE = video_pkg::DEF_H_VISIBLE,
    parameter int unsigned V_VISIBLE = video_pkg::DEF_V_VISIBLE
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               reg_wr_i,       // write strobe
    input  wire logic [3:0]         reg_num_i,      // register number
    input  wire logic [15:0]        reg_data_i,     // write data
    input  wire video_pkg::beam_t   beam_i,         // for scanline reads
    output video_pkg::vgen_cfg_t    cfg_o,          // live config
    output logic [15:0]             reg_data_o      // read data, one cycle late
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_o.start_addr  <= 16'h0000;
            cfg_o.line_width  <= 16'(H_VISIBLE / video_pkg::TILE_W);   // one tile row per line
            cfg_o.font_bank   <= 6'd0;
            cfg_o.font_height <= 4'd15;         // 8x16 cells
        end else if (reg_wr_i) begin
            case (reg_num_i)
                video_pkg::DISPSTART: begin
                    cfg_o.start_addr <= reg_data_i;
                end
                video_pkg::DISPWIDTH: begin
                    cfg_o.line_width <= reg_data_i;
                end
                video_pkg::FONTCTRL: begin
                    cfg_o.font_bank   <= reg_data_i[15:10];
                    cfg_o.font_height <= reg_data_i[3:0];
                end
                default: begin
                end
            endcase
        end
    end

    // read mux, registered every cycle
    always_ff @(posedge clk) begin
        case (reg_num_i)
            video_pkg::DISPSTART:  reg_data_o <= cfg_o.start_addr;
            video_pkg::DISPWIDTH:  reg_data_o <= cfg_o.line_width;
            video_pkg::FONTCTRL:   reg_data_o <= {cfg_o.font_bank, 6'b000000, cfg_o.font_height};
            video_pkg::R_WIDTH:    reg_data_o <= 16'(H_VISIBLE);
            video_pkg::R_HEIGHT:   reg_data_o <= 16'(V_VISIBLE);
            video_pkg::R_SCANLINE: begin
                // top bits set while blanking
                reg_data_o <= {~beam_i.v_visible, ~beam_i.h_visible, 3'b000, beam_i.v_count};
            end
            default:               reg_data_o <= 16'h0000;
        endcase
    end

endmodule

//--- hw/video_gen.sv
// ########################################
// text mode video generator top level
// ########################################
`timescale 1ns/10ps

module video_gen #(
    parameter int unsigned H_VISIBLE  = video_pkg::DEF_H_VISIBLE,
    parameter int unsigned H_FRONT    = video_pkg::DEF_H_FRONT,
    parameter int unsigned H_SYNC     = video_pkg::DEF_H_SYNC,
    parameter int unsigned H_BACK     = video_pkg::DEF_H_BACK,
    parameter int unsigned V_VISIBLE  = video_pkg::DEF_V_VISIBLE,
    parameter int unsigned V_FRONT    = video_pkg::DEF_V_FRONT,
    parameter int unsigned V_SYNC     = video_pkg::DEF_V_SYNC,
    parameter int unsigned V_BACK     = video_pkg::DEF_V_BACK,
    parameter bit          H_SYNC_POL = video_pkg::DEF_H_SYNC_POL,
    parameter bit          V_SYNC_POL = video_pkg::DEF_V_SYNC_POL
) (
    input  wire logic        clk,               // pixel clock
    input  wire logic        reset_i,
    input  wire logic        enable_i,          // 0 blanks from next frame
    input  wire logic        vgen_reg_wr_i,
    input  wire logic [3:0]  vgen_reg_num_i,
    input  wire logic [15:0] vgen_reg_data_i,
    output logic      [15:0] vgen_reg_data_o,
    input  wire logic [15:0] vram_data_i,
    input  wire logic [15:0] fontram_data_i,
    output logic             vram_sel_o,
    output logic      [15:0] vram_addr_o,
    output logic             fontram_sel_o,
    output logic      [11:0] fontram_addr_o,
    output logic      [3:0]  pal_index_o,
    output logic             hsync_o,
    output logic             vsync_o,
    output logic             dv_de_o
);

    video_pkg::beam_t     beam;                 // beam position and events
    video_pkg::vgen_cfg_t cfg;                  // live display config
    logic                 frame_en;

    video_timing #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .H_SYNC_POL(H_SYNC_POL), .V_SYNC_POL(V_SYNC_POL)
    ) timing0 (
        .clk(clk), .reset_i(reset_i), .enable_i(enable_i), .beam_o(beam),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o), .frame_en_o(frame_en)
    );

    vgen_regs #(
        .H_VISIBLE(H_VISIBLE), .V_VISIBLE(V_VISIBLE)
    ) regs0 (
        .clk(clk), .reset_i(reset_i), .reg_wr_i(vgen_reg_wr_i),
        .reg_num_i(vgen_reg_num_i), .reg_data_i(vgen_reg_data_i), .beam_i(beam),
        .cfg_o(cfg), .reg_data_o(vgen_reg_data_o)
    );

    text_plane text0 (
        .clk(clk), .reset_i(reset_i), .cfg_i(cfg), .beam_i(beam), .video_en_i(frame_en),
        .vram_data_i(vram_data_i), .fontram_data_i(fontram_data_i),
        .vram_sel_o(vram_sel_o), .fontram_sel_o(fontram_sel_o),
        .vram_addr_o(vram_addr_o), .fontram_addr_o(fontram_addr_o),
        .pal_index_o(pal_index_o)
    );

endmodule

//--- hw/video_pkg.sv
// ########################################
// video generator shared definitions
// register numbers, beam and config types, default 640x480 timing
// ########################################

package video_pkg;

    typedef enum logic [3:0] {
        DISPSTART  = 4'd0,                      // tile row start address (word)
        DISPWIDTH  = 4'd1,                      // words per tile row
        FONTCTRL   = 4'd3,                      // font bank and cell height
        R_WIDTH    = 4'd8,                      // visible width, read only
        R_HEIGHT   = 4'd9,                      // visible height, read only
        R_SCANLINE = 4'd11                      // live beam position, read only
    } vgen_reg_e;

    typedef enum logic [1:0] {
        PRE_SYNC  = 2'b00,                      // front porch
        SYNC      = 2'b01,                      // sync pulse
        POST_SYNC = 2'b10,                      // back porch
        VISIBLE   = 2'b11                       // active pixels
    } vstate_e;

    typedef struct packed {
        logic [15:0] start_addr;                // word address of first tile row
        logic [15:0] line_width;                // words per tile row
        logic [5:0]  font_bank;                 // font RAM bank
        logic [3:0]  font_height;               // last row index of a cell
    } vgen_cfg_t;

    typedef struct packed {
        logic        h_visible;                 // beam in visible columns
        logic        v_visible;                 // beam on a visible line
        logic        line_end;                  // last pixel of a line
        logic        frame_end;                 // last pixel of a frame
        logic        fetch_start;               // first cycle of line fetch
        logic        fetch_active;              // tile fetch window
        logic [10:0] v_count;                   // current line
    } beam_t;

    // 640x480 at 25.175 MHz
    localparam int unsigned DEF_H_VISIBLE = 640;
    localparam int unsigned DEF_H_FRONT   = 16;
    localparam int unsigned DEF_H_SYNC    = 96;
    localparam int unsigned DEF_H_BACK    = 48;
    localparam int unsigned DEF_V_VISIBLE = 480;
    localparam int unsigned DEF_V_FRONT   = 10;
    localparam int unsigned DEF_V_SYNC    = 2;
    localparam int unsigned DEF_V_BACK    = 33;
    localparam bit          DEF_H_SYNC_POL = 1'b0;     // negative hsync
    localparam bit          DEF_V_SYNC_POL = 1'b0;     // negative vsync

    localparam int unsigned FETCH_LEAD = 7;     // fetch_start to first pixel
    localparam int unsigned TILE_W     = 8;     // pixels per tile

endpackage

//--- hw/video_timing.sv
// ########################################
// beam timing, h and v sync state machines
// also makes beam events and the fetch window
// ########################################
`timescale 1ns/10ps

module video_timing #(
    parameter int unsigned H_VISIBLE  = video_pkg::DEF_H_VISIBLE,
    parameter int unsigned H_FRONT    = video_pkg::DEF_H_FRONT,
    parameter int unsigned H_SYNC     = video_pkg::DEF_H_SYNC,
    parameter int unsigned H_BACK     = video_pkg::DEF_H_BACK,
    parameter int unsigned V_VISIBLE  = video_pkg::DEF_V_VISIBLE,
    parameter int unsigned V_FRONT    = video_pkg::DEF_V_FRONT,
    parameter int unsigned V_SYNC     = video_pkg::DEF_V_SYNC,
    parameter int unsigned V_BACK     = video_pkg::DEF_V_BACK,
    parameter bit          H_SYNC_POL = video_pkg::DEF_H_SYNC_POL,
    parameter bit          V_SYNC_POL = video_pkg::DEF_V_SYNC_POL
) (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           enable_i,       // sampled at frame end
    output video_pkg::beam_t    beam_o,         // beam position and events
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o,        // display enable
    output logic                frame_en_o      // enable held for this frame
);

    localparam logic [10:0] H_OFF   = 11'(H_FRONT + H_SYNC + H_BACK);   // blank columns
    localparam logic [10:0] H_TOTAL = 11'(H_FRONT + H_SYNC + H_BACK + H_VISIBLE);
    localparam logic [10:0] V_TOTAL = 11'(V_VISIBLE + V_FRONT + V_SYNC + V_BACK);
    localparam logic [10:0] FETCH_BEGIN = H_OFF - 11'(video_pkg::FETCH_LEAD);
    localparam logic [10:0] FETCH_END   = H_TOTAL - 11'(video_pkg::FETCH_LEAD);

    video_pkg::vstate_e h_state;
    video_pkg::vstate_e v_state;
    logic [10:0]        h_count;
    logic [10:0]        v_count;
    logic [10:0]        h_bound;                // last count of current h state
    logic [10:0]        v_bound;                // last line of current v state
    logic               h_step;
    logic               v_step;
    logic               line_end;
    logic               frame_end;

    // line is front porch, sync, back porch, then visible
    always_comb begin
        case (h_state)
            video_pkg::PRE_SYNC:  h_bound = 11'(H_FRONT - 1);
            video_pkg::SYNC:      h_bound = 11'(H_FRONT + H_SYNC - 1);
            video_pkg::POST_SYNC: h_bound = H_OFF - 11'd1;
            default:              h_bound = H_TOTAL - 11'd1;
        endcase
    end

    // frame is visible first, blanking at the bottom
    always_comb begin
        case (v_state)
            video_pkg::VISIBLE:  v_bound = 11'(V_VISIBLE - 1);
            video_pkg::PRE_SYNC: v_bound = 11'(V_VISIBLE + V_FRONT - 1);
            video_pkg::SYNC:     v_bound = 11'(V_VISIBLE + V_FRONT + V_SYNC - 1);
            default:             v_bound = V_TOTAL - 11'd1;
        endcase
    end

    always_comb begin
        h_step    = (h_count == h_bound);
        line_end  = h_step && (h_state == video_pkg::VISIBLE);
        v_step    = line_end && (v_count == v_bound);           // v only moves at line end
        frame_end = v_step && (v_state == video_pkg::POST_SYNC);

        beam_o.h_visible    = (h_state == video_pkg::VISIBLE);
        beam_o.v_visible    = (v_state == video_pkg::VISIBLE);
        beam_o.line_end     = line_end;
        beam_o.frame_end    = frame_end;
        beam_o.fetch_start  = beam_o.v_visible && (h_count == FETCH_BEGIN);
        beam_o.fetch_active = beam_o.v_visible && (h_count >= FETCH_BEGIN)
                              && (h_count < FETCH_END);        // no fetch past last tile
        beam_o.v_count      = v_count;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state    <= video_pkg::PRE_SYNC;
            v_state    <= video_pkg::VISIBLE;
            h_count    <= 11'd0;
            v_count    <= 11'd0;
            frame_en_o <= 1'b1;                 // video on out of reset
            hsync_o    <= 1'b0;
            vsync_o    <= 1'b0;
            dv_de_o    <= 1'b0;
        end else begin
            h_count <= line_end ? 11'd0 : h_count + 11'd1;
            if (h_step) begin
                h_state <= video_pkg::vstate_e'(h_state + 2'd1);  // wraps visible to pre sync
            end
            if (line_end) begin
                v_count <= frame_end ? 11'd0 : v_count + 11'd1;
            end
            if (v_step) begin
                v_state <= video_pkg::vstate_e'(v_state + 2'd1);
            end
            if (frame_end) begin
                frame_en_o <= enable_i;         // takes effect on next frame
            end

            // outputs lag the beam by one cycle
            hsync_o <= (h_state == video_pkg::SYNC) ? H_SYNC_POL : ~H_SYNC_POL;
            vsync_o <= (v_state == video_pkg::SYNC) ? V_SYNC_POL : ~V_SYNC_POL;
            dv_de_o <= frame_en_o && beam_o.h_visible && beam_o.v_visible;
        end
    end

endmodule

//--- verification/tb_clock.sv
// ########################################
// testbench clock and reset source
// ########################################
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic reset_i
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                  // 10 ns period
    end

    initial begin
        reset_i = 1'b1;
        repeat (2) @(posedge clk);              // two reset cycles
        #1 reset_i = 1'b0;
    end

endmodule

//--- verification/video_gen_tb.sv
// ########################################
// video generator testbench, 32x6 mode
// beam, register and text models with random memories
// ########################################
`timescale 1ns/10ps

module video_gen_tb;

    localparam int HV = 32;                     // small mode timing
    localparam int HF = 2;
    localparam int HS = 3;
    localparam int HB = 2;
    localparam int VV = 6;
    localparam int VF = 1;
    localparam int VS = 1;
    localparam int VB = 1;
    localparam bit H_POL = 1'b1;
    localparam bit V_POL = 1'b0;
    localparam int H_OFF = HF + HS + HB;
    localparam int H_TOT = H_OFF + HV;
    localparam int V_TOT = VV + VF + VS + VB;
    localparam int TIMEOUT = 4 * H_TOT * V_TOT; // four frames

    logic        clk;
    logic        reset_i;
    logic        enable_i;
    logic        reg_wr;
    logic [3:0]  reg_num;
    logic [15:0] reg_wdata;
    logic [15:0] reg_rdata;
    logic [15:0] vram_data;
    logic [15:0] fontram_data;
    logic        vram_sel;
    logic [15:0] vram_addr;
    logic        fontram_sel;
    logic [11:0] fontram_addr;
    logic [3:0]  pal_index;
    logic        hsync;
    logic        vsync;
    logic        dv_de;

    logic [15:0] vram_mem [0:65535];
    logic [15:0] font_mem [0:4095];
    logic        vsel_q;                        // selects seen on the last cycle
    logic        fsel_q;
    logic [15:0] vaddr_q;
    logic [11:0] faddr_q;

    int          mh;                            // beam model position
    int          mv;
    logic        m_en;
    logic        have_prev;
    logic        p_hs;                          // beam of previous cycle
    logic        p_vs;
    logic        p_de;
    int          p_h;
    int          p_v;
    logic [15:0] scan_snap;
    int          frame_cnt;
    int          sel_cnt;
    int          de_cnt;

    logic        text_on;                       // pixel check armed
    logic [15:0] c_start;                       // config model
    logic [15:0] c_width;
    logic [5:0]  c_bank;
    logic [3:0]  c_fh;

    tb_clock clock0 (.clk(clk), .reset_i(reset_i));

    video_gen #(
        .H_VISIBLE(HV), .H_FRONT(HF), .H_SYNC(HS), .H_BACK(HB),
        .V_VISIBLE(VV), .V_FRONT(VF), .V_SYNC(VS), .V_BACK(VB),
        .H_SYNC_POL(H_POL), .V_SYNC_POL(V_POL)
    ) dut0 (
        .clk(clk), .reset_i(reset_i), .enable_i(enable_i),
        .vgen_reg_wr_i(reg_wr), .vgen_reg_num_i(reg_num), .vgen_reg_data_i(reg_wdata),
        .vgen_reg_data_o(reg_rdata), .vram_data_i(vram_data), .fontram_data_i(fontram_data),
        .vram_sel_o(vram_sel), .vram_addr_o(vram_addr), .fontram_sel_o(fontram_sel),
        .fontram_addr_o(fontram_addr), .pal_index_o(pal_index),
        .hsync_o(hsync), .vsync_o(vsync), .dv_de_o(dv_de)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_sync(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[ERROR] %s expected %b actual %b", name, exp, act);
            abort_run("sync output mismatch");
        end
    endtask

    task automatic check_reg(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            abort_run("register read mismatch");
        end
    endtask

    task automatic check_pixel(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            abort_run("pixel mismatch");
        end
    endtask

    // color of pixel x on line y from the memories and the config
    function automatic logic [3:0] text_color(input int x, input int y);
        int          rows;
        logic [3:0]  c;
        logic [15:0] row_addr;
        logic [15:0] tile;
        logic [15:0] fa;
        logic [15:0] fw;
        logic [7:0]  fbyte;
        rows     = int'(c_fh) + 1;
        c        = 4'(y % rows);
        row_addr = c_start + 16'(y / rows) * c_width;
        tile     = vram_mem[row_addr + 16'(x / 8)];
        if (c_fh[3]) begin
            fa = {c_bank[5:1], tile[7:0], c[3:1]};
        end else begin
            fa = {c_bank, tile[7:0], c[2:1]};
        end
        fw    = font_mem[fa[11:0]];
        fbyte = c[0] ? fw[7:0] : fw[15:8];      // even rows in high byte
        return fbyte[7 - (x % 8)] ? tile[11:8] : tile[15:12];
    endfunction

    // memory models answer one cycle after the select
    always @(negedge clk) begin
        vsel_q  = vram_sel;
        fsel_q  = fontram_sel;
        vaddr_q = vram_addr;
        faddr_q = fontram_addr;
        if (vram_sel || fontram_sel) sel_cnt++;
    end

    always @(posedge clk) begin
        #1;
        if (vsel_q) vram_data = vram_mem[vaddr_q];
        if (fsel_q) fontram_data = font_mem[faddr_q];
    end

    // beam model and output checks, sampled mid cycle
    always @(negedge clk) begin
        logic hvis;
        logic vvis;
        if (reset_i) begin
            mh        = 0;
            mv        = 0;
            m_en      = 1'b1;
            have_prev = 1'b0;
        end else begin
            if (have_prev) begin
                check_sync("hsync", p_hs, hsync);
                check_sync("vsync", p_vs, vsync);
                check_sync("dv_de", p_de, dv_de);
                if (dv_de) de_cnt++;
                if (dv_de && text_on) begin
                    check_pixel("text", text_color(p_h - H_OFF, p_v), pal_index);
                end
            end
            hvis      = (mh >= H_OFF);
            vvis      = (mv < VV);
            p_hs      = (mh >= HF && mh < HF + HS) ? H_POL : ~H_POL;
            p_vs      = (mv == VV + VF) ? V_POL : ~V_POL;
            p_de      = m_en && hvis && vvis;
            p_h       = mh;
            p_v       = mv;
            scan_snap = {~vvis, ~hvis, 3'b000, 11'(mv)};
            have_prev = 1'b1;
            if (mh == H_TOT - 1) begin
                mh = 0;
                if (mv == V_TOT - 1) begin
                    mv   = 0;
                    m_en = enable_i;            // frame enable latched at frame end
                    frame_cnt++;
                end else begin
                    mv++;
                end
            end else begin
                mh++;
            end
        end
    end

    task automatic wait_frame_end();
        int start;
        int n;
        start = frame_cnt;
        n     = 0;
        while (frame_cnt == start) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) abort_run("timed out waiting for a frame end");
        end
        #1;
    endtask

    task automatic wait_line(input int line);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        while (!(mv == line && mh == 0)) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) abort_run("timed out waiting for a line start");
        end
    endtask

    task automatic reg_write(input logic [3:0] num, input logic [15:0] data);
        reg_wr    = 1'b1;
        reg_num   = num;
        reg_wdata = data;
        @(posedge clk);
        #1;
        reg_wr    = 1'b0;
        if (num == 4'd0) c_start = data;
        if (num == 4'd1) c_width = data;
        if (num == 4'd3) begin
            c_bank = data[15:10];
            c_fh   = data[3:0];
        end
    endtask

    task automatic reg_read(input logic [3:0] num, output logic [15:0] data);
        reg_num = num;
        @(posedge clk);
        #1;
        data = reg_rdata;
    endtask

    initial begin
        logic [15:0] rd;
        int          n;
        enable_i     = 1'b1;
        reg_wr       = 1'b0;
        reg_num      = 4'd0;
        reg_wdata    = 16'h0000;
        vram_data    = 16'h0000;
        fontram_data = 16'h0000;
        frame_cnt    = 0;
        sel_cnt      = 0;
        de_cnt       = 0;
        text_on      = 1'b0;
        c_start      = 16'h0000;
        c_width      = 16'(HV / 8);
        c_bank       = 6'd0;
        c_fh         = 4'd15;
        void'($urandom(63));
        for (int i = 0; i < 65536; i++) vram_mem[i] = 16'($urandom);
        for (int i = 0; i < 4096; i++) font_mem[i] = 16'($urandom);

        n = 0;
        while (reset_i !== 1'b0) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) abort_run("reset never released");
        end
        @(posedge clk);
        #1;

        // register reads of fixed and writable registers
        reg_read(4'd8, rd);
        check_reg("r_width", 16'(HV), rd);
        reg_read(4'd9, rd);
        check_reg("r_height", 16'(VV), rd);
        for (int i = 0; i < 8; i++) begin
            reg_write(4'd0, 16'($urandom));
            reg_write(4'd1, 16'($urandom));
            reg_write(4'd3, 16'($urandom));
            reg_read(4'd0, rd);
            check_reg("dispstart", c_start, rd);
            reg_read(4'd1, rd);
            check_reg("dispwidth", c_width, rd);
            reg_read(4'd3, rd);
            check_reg("fontctrl", {c_bank, 6'b000000, c_fh}, rd);
            reg_write(4'd2, 16'($urandom));
            for (int r = 0; r < 16; r++) begin
                if (r != 0 && r != 1 && r != 3 && r != 8 && r != 9 && r != 11) begin
                    reg_read(4'(r), rd);
                    check_reg("unused", 16'h0000, rd);
                end
            end
        end

        // scanline reads at random cycles
        for (int i = 0; i < 40; i++) begin
            repeat ($urandom_range(0, 60)) begin
                @(posedge clk);
                #1;
            end
            reg_read(4'd11, rd);
            check_reg("r_scanline", scan_snap, rd);
        end

        // text pixels, config changed in vertical blanking
        for (int i = 0; i < 4; i++) begin
            wait_line(VV);
            reg_write(4'd0, 16'($urandom));
            reg_write(4'd1, 16'($urandom_range(1, 40)));
            reg_write(4'd3, 16'($urandom));
            text_on = 1'b1;
            wait_frame_end();
            wait_frame_end();
        end

        // enable low blanks exactly one frame
        wait_line(VV);
        enable_i = 1'b0;
        wait_frame_end();
        sel_cnt  = 0;
        de_cnt   = 0;
        enable_i = 1'b1;
        wait_frame_end();
        if (sel_cnt != 0 || de_cnt != 0) begin
            abort_run("video was active in the disabled frame");
        end
        de_cnt = 0;
        wait_frame_end();
        if (de_cnt != HV * VV) begin
            abort_run("video did not come back after enable");
        end

        $display("All tests passed");
        $finish;
    end

endmodule

//--- video_gen.f
hw/video_pkg.sv
hw/video_timing.sv
hw/vgen_regs.sv
hw/text_plane.sv
hw/video_gen.sv
verification/tb_clock.sv
verification/video_gen_tb.sv
